// File: dv/soc_tb.sv
`timescale 1ns/1ns

module soc_tb;

   localparam int baud_div = 8;
   localparam int sram_addr_w = 10;
   localparam int period = 4;
   localparam logic [7:0] comment_char = "#";

   logic                         clk = 1'b0;
   logic                         rst;
   logic                         valid;
   logic [soc_pkg::addr_w-1:0]   addr;
   logic [soc_pkg::data_w-1:0]   wdata;
   logic [soc_pkg::strb_w-1:0]   wstrb;
   logic [soc_pkg::data_w-1:0]   rdata;
   logic                         ready;
   logic                         txd;
   logic                         cts;

   // one queue per test file column
   logic [7:0]  op_q[$];
   logic [15:0] addr_q[$];
   logic [31:0] data_q[$];
   logic [3:0]  strb_q[$];
   logic [31:0] exp_q[$];
   logic        tests_loaded = 1'b0;

   logic [7:0]  rx_q[$];
   logic [31:0] lcg_state = 32'd6;

   soc_top #(
      .SRAM_ADDR_W (sram_addr_w),
      .BAUD_DIV    (baud_div)
   ) dut0 (
      .clk   (clk),
      .rst   (rst),
      .valid (valid),
      .addr  (addr),
      .wdata (wdata),
      .wstrb (wstrb),
      .rdata (rdata),
      .ready (ready),
      .txd   (txd),
      .cts   (cts)
   );

   always #(period / 2) clk = ~clk;

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // spread n words evenly from index 0 up to the top index
   function automatic logic [15:0] spread_addr(input int j, input int n);
      int idx;
      idx = (j * ((1 << sram_addr_w) - 1)) / ((n > 1) ? n - 1 : 1);
      return 16'(idx * 4);
   endfunction

   task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("Error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
         $display("Regression failed");
         $fatal(1, "stopped at the first mismatch");
      end
   endtask

   task automatic load_tests();
      int          fd;
      int          n;
      string       line;
      logic [7:0]  op;
      logic [31:0] a;
      logic [31:0] d;
      logic [31:0] s;
      logic [31:0] e;
      fd = $fopen("dv/soc_tests.txt", "r");
      if (fd == 0) begin
         $display("Regression failed");
         $fatal(1, "could not open the test file dv/soc_tests.txt");
      end else begin
         while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line.getc(0) != comment_char) begin
               n = $sscanf(line, "%c %h %h %h %h", op, a, d, s, e);
               if (n != 5) begin
                  $display("Regression failed");
                  $fatal(1, "a test line could not be parsed: %s", line);
               end else begin
                  op_q.push_back(op);
                  addr_q.push_back(a[15:0]);
                  data_q.push_back(d);
                  strb_q.push_back(s[3:0]);
                  exp_q.push_back(e);
               end
            end
         end
         $fclose(fd);
      end
   endtask

   task automatic bus_access(input logic [15:0] a, input logic [31:0] d, input logic [3:0] s,
                             output logic [31:0] rd);
      int cycles;
      @(posedge clk);
      valid <= 1'b1;
      addr <= a;
      wdata <= d;
      wstrb <= s;
      // middle of the first valid cycle
      @(negedge clk);
      check($sformatf("early ready at %h", a), {31'b0, ready}, 32'd0);
      cycles = 0;
      while (ready !== 1'b1) begin
         @(negedge clk);
         cycles++;
      end
      rd = rdata;
      check($sformatf("ready latency at %h", a), cycles, 32'd1);
      @(posedge clk);
      valid <= 1'b0;
      wstrb <= '0;
      @(negedge clk);
      check($sformatf("ready pulse width at %h", a), {31'b0, ready}, 32'd0);
   endtask

   task automatic poll_status(input logic [15:0] a, input logic [31:0] exp);
      logic [31:0] rd;
      do begin
         bus_access(a, '0, '0, rd);
      end while (rd[soc_pkg::uart_stat_busy] === 1'b1);
      check("uart status after poll", rd, exp);
      check("txd idle after poll", {31'b0, txd}, 32'd1);
   endtask

   task automatic expect_uart_byte(input logic [7:0] exp);
      logic [7:0] got;
      while (rx_q.size() == 0) begin
         @(negedge clk);
      end
      got = rx_q.pop_front();
      check("uart byte", {24'b0, got}, {24'b0, exp});
   endtask

   task automatic fill_sram_random(input int n);
      logic [31:0] saved;
      logic [31:0] rd;
      logic [31:0] word;
      logic [15:0] a;
      saved = lcg_state;
      for (int j = 0; j < n; j++) begin
         a = spread_addr(j, n);
         word = next_rand() ^ {16'h0, a};
         bus_access(a, word, 4'hf, rd);
      end
      // replay the generator for the read back
      lcg_state = saved;
      for (int j = 0; j < n; j++) begin
         a = spread_addr(j, n);
         word = next_rand() ^ {16'h0, a};
         bus_access(a, '0, '0, rd);
         check($sformatf("random word at %h", a), rd, word);
      end
   endtask

   // txd receiver
   // start bit rechecked at mid-bit to skip aborted frames
   initial begin
      logic [7:0] byte_val;
      forever begin
         @(negedge clk);
         if (rst === 1'b0 && txd === 1'b0) begin
            repeat (baud_div / 2) @(negedge clk);
            if (txd === 1'b0) begin
               for (int i = 0; i < 8; i++) begin
                  repeat (baud_div) @(negedge clk);
                  byte_val[i] = txd;
               end
               repeat (baud_div) @(negedge clk);
               check("uart stop bit", {31'b0, txd}, 32'd1);
               rx_q.push_back(byte_val);
            end
         end
      end
   end

   initial begin
      int limit;
      wait (tests_loaded);
      limit = op_q.size() * 20 * baud_div;
      repeat (limit) @(posedge clk);
      $display("Regression failed");
      $fatal(1, "watchdog expired after %0d cycles, the tests did not finish", limit);
   end

   initial begin
      logic [31:0] rd;
      rst <= 1'b1;
      valid <= 1'b0;
      addr <= '0;
      wdata <= '0;
      wstrb <= '0;
      cts <= 1'b1;
      load_tests();
      tests_loaded = 1'b1;
      repeat (2) @(posedge clk);
      rst <= 1'b0;
      for (int i = 0; i < op_q.size(); i++) begin
         case (op_q[i])
            "W": bus_access(addr_q[i], data_q[i], strb_q[i], rd);
            "R": begin
               bus_access(addr_q[i], '0, '0, rd);
               check($sformatf("read at %h", addr_q[i]), rd, exp_q[i]);
            end
            "P": poll_status(addr_q[i], exp_q[i]);
            "U": expect_uart_byte(exp_q[i][7:0]);
            "C": begin
               @(posedge clk);
               cts <= data_q[i][0];
            end
            "L": fill_sram_random(int'(data_q[i]));
            default: begin
               $display("Regression failed");
               $fatal(1, "unknown operation in test line %0d", i);
            end
         endcase
      end
      // dropped writes must not show up on txd
      check("uart bytes never expected", rx_q.size(), 32'd0);
      $display("Regression passed");
      $finish;
   end

endmodule

// File: dv/soc_tests.txt
# op addr data strb expect, all fields hex
# W write, R read, P poll uart status, U uart byte, C cts level, L random sram words
R D000 00000000 0 00000000
W D000 DEADBEEF F 00000000
R 8000 00000000 0 00000000
R 9004 00000000 0 00000002
W 0014 11223344 F 00000000
W 0014 AABBCCDD 5 00000000
R 0014 00000000 0 11BB33DD
W 0FA0 01020304 F 00000000
W 0FA0 CAFEBE00 A 00000000
R 0FA0 00000000 0 CA02BE04
L 0000 00000020 0 00000000
W 9000 00000041 1 00000000
R 9004 00000000 0 00000003
W 9000 0000005A 1 00000000
U 0000 00000000 0 00000041
P 9004 00000000 0 00000002
C 0000 00000000 0 00000000
W 9000 00000033 1 00000000
R 9004 00000000 0 00000000
C 0000 00000001 0 00000000
R 9004 00000000 0 00000002
W 9000 000000C3 1 00000000
U 0000 00000000 0 000000C3
P 9004 00000000 0 00000002
W 9000 00000000 1 00000000
W 8000 00000001 1 00000000
P 9004 00000000 0 00000002
R 8000 00000000 0 00000001
W 8000 00000000 1 00000000
W 8000 00000001 1 00000000
R 8000 00000000 0 00000002
R 0014 00000000 0 11BB33DD
R 0FA0 00000000 0 CA02BE04
L 0000 00000007 0 00000000
R F000 00000000 0 00000000

// File: flist.f
source/soc_pkg.sv
source/soc_addr_decode.sv
source/int_sram.sv
source/uart_tx_periph.sv
source/soft_rst_ctl.sv
source/soc_top.sv
dv/soc_tb.sv

// File: run_sim.sh
#!/bin/sh
# build with verilator, run, then decide on the simulation log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing -Wno-fatal --top-module soc_tb -f flist.f -o soc_sim \
   > build.log 2>&1 || { cat build.log; echo "verilator build failed"; exit 1; }
./obj_dir/soc_sim > sim.log 2>&1
cat sim.log
grep -q "Regression failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Regression passed" sim.log || { echo "FAIL, no pass line in sim.log"; exit 1; }
echo "PASS"
exit 0

// File: source/int_sram.sv
`timescale 1ns/1ns

module int_sram #(
   parameter int ADDR_W = 10
) (
   input  logic                          clk,
   input  logic                          valid,
   input  logic [ADDR_W-1:0]             addr,
   input  logic [soc_pkg::data_w-1:0]    wdata,
   input  logic [soc_pkg::strb_w-1:0]    wstrb,
   output logic [soc_pkg::data_w-1:0]    rdata,
   output logic                          ready
);

   localparam int depth = 2 ** ADDR_W;

   logic [soc_pkg::data_w-1:0] mem [0:depth-1];
   logic                       access;

   // first cycle of a request only
   assign access = valid & ~ready;

   always_ff @(posedge clk) begin
      ready <= access;
   end

   // byte lanes
   always_ff @(posedge clk) begin
      if (access) begin
         for (int i = 0; i < soc_pkg::strb_w; i++) begin
            if (wstrb[i]) begin
               mem[addr][8*i +: 8] <= wdata[8*i +: 8];
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (access) begin
         rdata <= mem[addr];
      end
   end

endmodule

// File: source/soc_addr_decode.sv
`timescale 1ns/1ns

module soc_addr_decode (
   input  logic                                         clk,
   input  logic                                         rst,
   input  logic                                         valid,
   input  soc_pkg::soc_addr_u                           addr,
   output logic                                         ready,
   output logic [soc_pkg::data_w-1:0]                   rdata,
   output logic                                         sram_valid,
   input  logic                                         sram_ready,
   input  logic [soc_pkg::data_w-1:0]                   sram_rdata,
   output logic [soc_pkg::n_slots-1:0]                  slot_valid,
   input  logic [soc_pkg::n_slots-1:0]                  slot_ready,
   input  logic [soc_pkg::n_slots*soc_pkg::data_w-1:0]  slot_rdata
);

   logic populated;
   logic empty_valid;
   logic empty_ready;

   // only the reset controller and the uart sit on the slot bus
   assign populated = (addr.per.slot == soc_pkg::slot_rst) ||
                      (addr.per.slot == soc_pkg::slot_uart);

   always_comb begin
      sram_valid = 1'b0;
      slot_valid = '0;
      empty_valid = 1'b0;
      ready = sram_ready;
      rdata = sram_rdata;
      if (addr.mem.region) begin
         if (populated) begin
            slot_valid[addr.per.slot] = valid;
            ready = slot_ready[addr.per.slot];
            rdata = slot_rdata[addr.per.slot*soc_pkg::data_w +: soc_pkg::data_w];
         end else begin
            // empty slot answered locally with zero data
            empty_valid = valid;
            ready = empty_ready;
            rdata = '0;
         end
      end else begin
         sram_valid = valid;
      end
   end

   // one-cycle responder for unpopulated slots
   always_ff @(posedge clk) begin
      if (rst) begin
         empty_ready <= 1'b0;
      end else begin
         empty_ready <= empty_valid & ~empty_ready;
      end
   end

endmodule

// File: source/soc_pkg.sv
package soc_pkg;

   // bus geometry
   localparam int addr_w = 16;
   localparam int data_w = 32;
   localparam int strb_w = 4;

   // peripheral slave index
   localparam int slot_w = 3;
   localparam int n_slots = 2 ** slot_w;

   localparam logic [slot_w-1:0] slot_rst = 3'd0;
   localparam logic [slot_w-1:0] slot_uart = 3'd1;

   // uart register offsets
   localparam logic [1:0] uart_reg_data = 2'd0;
   localparam logic [1:0] uart_reg_status = 2'd1;

   // status register bits
   localparam int uart_stat_busy = 0;
   localparam int uart_stat_cts = 1;

   // one address word, decoded as memory or peripheral access
   typedef union packed {
      struct packed {
         logic        region;
         logic [12:0] word_idx;
         logic [1:0]  byte_off;
      } mem;
      struct packed {
         logic              region;
         logic [slot_w-1:0] slot;
         logic [7:0]        unused;
         logic [1:0]        reg_off;
         logic [1:0]        byte_off;
      } per;
   } soc_addr_u;

endpackage

// File: source/soc_top.sv
`timescale 1ns/1ns

module soc_top #(
   parameter int SRAM_ADDR_W = 10,
   parameter int BAUD_DIV = 8
) (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        valid,
   input  logic [soc_pkg::addr_w-1:0]  addr,
   input  logic [soc_pkg::data_w-1:0]  wdata,
   input  logic [soc_pkg::strb_w-1:0]  wstrb,
   output logic [soc_pkg::data_w-1:0]  rdata,
   output logic                        ready,
   output logic                        txd,
   input  logic                        cts
);

   soc_pkg::soc_addr_u                          addr_u;
   logic                                        int_rst;
   logic                                        soft_rst;
   logic                                        write;
   logic                                        sram_valid;
   logic                                        sram_ready;
   logic [soc_pkg::data_w-1:0]                  sram_rdata;
   logic [soc_pkg::n_slots-1:0]                 slot_valid;
   logic [soc_pkg::n_slots-1:0]                 slot_ready;
   logic [soc_pkg::n_slots*soc_pkg::data_w-1:0] slot_rdata;
   logic                                        uart_ready;
   logic [soc_pkg::data_w-1:0]                  uart_rdata;
   logic                                        rstc_ready;
   logic [soc_pkg::data_w-1:0]                  rstc_rdata;

   assign addr_u = addr;
   assign int_rst = rst | soft_rst;
   assign write = |wstrb;

   // gather slot responses
   always_comb begin
      slot_ready = '0;
      slot_rdata = '0;
      slot_ready[soc_pkg::slot_rst] = rstc_ready;
      slot_ready[soc_pkg::slot_uart] = uart_ready;
      slot_rdata[soc_pkg::slot_rst*soc_pkg::data_w +: soc_pkg::data_w] = rstc_rdata;
      slot_rdata[soc_pkg::slot_uart*soc_pkg::data_w +: soc_pkg::data_w] = uart_rdata;
   end

   soc_addr_decode dec0 (
      .clk        (clk),
      .rst        (int_rst),
      .valid      (valid),
      .addr       (addr_u),
      .ready      (ready),
      .rdata      (rdata),
      .sram_valid (sram_valid),
      .sram_ready (sram_ready),
      .sram_rdata (sram_rdata),
      .slot_valid (slot_valid),
      .slot_ready (slot_ready),
      .slot_rdata (slot_rdata)
   );

   int_sram #(
      .ADDR_W (SRAM_ADDR_W)
   ) sram0 (
      .clk   (clk),
      .valid (sram_valid),
      .addr  (addr_u.mem.word_idx[SRAM_ADDR_W-1:0]),
      .wdata (wdata),
      .wstrb (wstrb),
      .rdata (sram_rdata),
      .ready (sram_ready)
   );

   uart_tx_periph #(
      .BAUD_DIV (BAUD_DIV)
   ) uart0 (
      .clk     (clk),
      .rst     (int_rst),
      .valid   (slot_valid[soc_pkg::slot_uart]),
      .reg_sel (addr_u.per.reg_off),
      .wdata   (wdata[7:0]),
      .write   (write),
      .rdata   (uart_rdata),
      .ready   (uart_ready),
      .txd     (txd),
      .cts     (cts)
   );

   // soft reset count is cleared by the hard reset only
   soft_rst_ctl rstc0 (
      .clk      (clk),
      .rst      (rst),
      .valid    (slot_valid[soc_pkg::slot_rst]),
      .wdata    (wdata[0]),
      .write    (write),
      .rdata    (rstc_rdata),
      .ready    (rstc_ready),
      .soft_rst (soft_rst)
   );

endmodule

// File: source/soft_rst_ctl.sv
`timescale 1ns/1ns

module soft_rst_ctl (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        valid,
   input  logic [0:0]                  wdata,
   input  logic                        write,
   output logic [soc_pkg::data_w-1:0]  rdata,
   output logic                        ready,
   output logic                        soft_rst
);

   logic       access;
   logic       issue;
   logic [7:0] rst_cnt;

   assign access = valid & ~ready;
   assign issue = access & write & wdata[0];

   // pulse lines up with the edge of ready
   always_ff @(posedge clk) begin
      if (rst) begin
         ready <= 1'b0;
         soft_rst <= 1'b0;
         rst_cnt <= '0;
      end else begin
         ready <= access;
         soft_rst <= issue;
         if (issue) begin
            rst_cnt <= rst_cnt + 8'd1;
         end
      end
   end

   // reads return the soft reset count
   always_ff @(posedge clk) begin
      if (access) begin
         rdata <= {{(soc_pkg::data_w-8){1'b0}}, rst_cnt};
      end
   end

endmodule

// File: source/uart_tx_periph.sv
`timescale 1ns/1ns

module uart_tx_periph #(
   parameter int BAUD_DIV = 8
) (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        valid,
   input  logic [1:0]                  reg_sel,
   input  logic [7:0]                  wdata,
   input  logic                        write,
   output logic [soc_pkg::data_w-1:0]  rdata,
   output logic                        ready,
   output logic                        txd,
   input  logic                        cts
);

   localparam int div_w = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;
   localparam logic [div_w-1:0] div_last = div_w'(BAUD_DIV - 1);

   logic             access;
   logic             start;
   logic             busy;
   logic             bit_end;
   logic [9:0]       shreg;
   logic [3:0]       bit_cnt;
   logic [div_w-1:0] div_cnt;

   assign access = valid & ~ready;

   // writes while busy or with cts low are dropped
   assign start = access & write & (reg_sel == soc_pkg::uart_reg_data) & ~busy & cts;

   assign bit_end = (div_cnt == div_last);

   // idle line is high
   assign txd = busy ? shreg[0] : 1'b1;

   always_ff @(posedge clk) begin
      ready <= access;
      if (access) begin
         rdata <= '0;
         if (reg_sel == soc_pkg::uart_reg_status) begin
            rdata[soc_pkg::uart_stat_busy] <= busy;
            rdata[soc_pkg::uart_stat_cts] <= cts;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         busy <= 1'b0;
         bit_cnt <= '0;
         div_cnt <= '0;
      end else if (start) begin
         busy <= 1'b1;
         bit_cnt <= '0;
         div_cnt <= '0;
      end else if (busy) begin
         if (bit_end) begin
            div_cnt <= '0;
            // stop bit done
            if (bit_cnt == 4'd9) begin
               busy <= 1'b0;
            end else begin
               bit_cnt <= bit_cnt + 4'd1;
            end
         end else begin
            div_cnt <= div_cnt + 1'b1;
         end
      end
   end

   // stop, data lsb first, start
   always_ff @(posedge clk) begin
      if (start) begin
         shreg <= {1'b1, wdata, 1'b0};
      end else if (busy && bit_end) begin
         shreg <= {1'b1, shreg[9:1]};
      end
   end

endmodule
